/* include/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath word width. Only 32 is supported.
`define CFG_DATA_WIDTH 32

// Bit 6 of a register address picks the exception bank.
`define CFG_RF_ADDR_WIDTH 7

`define CFG_GPR_COUNT 32
`define CFG_EXC_REG_COUNT 8

// This code still commits its register write when the EPC is word aligned.
`define CFG_COMMIT_EXC 6

`endif

/* list.f */
+incdir+include
rtl/dataPkg.sv
rtl/trapPkg.sv
rtl/memAccess.sv
rtl/writeBack.sv
rtl/regFile.sv
rtl/memWbTop.sv
test/wbMemModel.sv
test/memWbTop_asserts.sv
test/memWbTop_tb.sv

/* rtl/dataPkg.sv */
`include "cpu_cfg.svh"

package dataPkg;

    typedef logic [`CFG_DATA_WIDTH-1:0] wordT;
    typedef logic [`CFG_RF_ADDR_WIDTH-1:0] regAddrT;
    typedef logic [2*`CFG_DATA_WIDTH-1:0] hiLoT; // HI in the upper word.

    // Bits 1..0 give the access size, bit 2 asks for sign extension.
    typedef logic [2:0] loadTypeT;

    // Access size codes found in loadTypeT bits 1..0.
    localparam logic [1:0] sizeByte = 2'd0;
    localparam logic [1:0] sizeHalf = 2'd1;
    localparam logic [1:0] sizeWord = 2'd2;

endpackage

/* rtl/memAccess.sv */
module memAccess
(
    input  logic              clk,
    input  logic              rst,
    input  logic              memValid,
    input  dataPkg::wordT     aluOut,
    input  dataPkg::wordT     storeData,
    input  dataPkg::loadTypeT loadType,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              regWrite,
    input  logic              memToReg,
    input  dataPkg::regAddrT  rfAddr,
    input  logic              hiLoWrite,
    input  dataPkg::hiLoT     hiLoData,
    input  dataPkg::wordT     pc,
    input  dataPkg::wordT     epc,
    input  trapPkg::excCodeT  excCode,
    input  logic              excAddrSel,
    input  logic              excDataSel,
    input  dataPkg::regAddrT  excAddr,
    input  dataPkg::wordT     excData,
    input  logic              syscall,
    input  logic              brk,
    output logic              stall,
    output logic              wbCyc,
    output logic              wbStb,
    output logic              wbWe,
    output dataPkg::wordT     wbAdr,
    output dataPkg::wordT     wbDatW,
    output logic [3:0]        wbSel,
    input  dataPkg::wordT     wbDatR,
    input  logic              wbAck,
    output logic              wbValid,
    output dataPkg::wordT     wbAluOut,
    output dataPkg::wordT     wbMemData,
    output dataPkg::loadTypeT wbLoadType,
    output logic              wbRegWrite,
    output logic              wbMemToReg,
    output dataPkg::regAddrT  wbRfAddr,
    output logic              wbHiLoWrite,
    output dataPkg::hiLoT     wbHiLoData,
    output dataPkg::wordT     wbPc,
    output dataPkg::wordT     wbEpc,
    output trapPkg::excCodeT  wbExcCode,
    output logic              wbExcAddrSel,
    output logic              wbExcDataSel,
    output dataPkg::regAddrT  wbExcAddr,
    output dataPkg::wordT     wbExcData,
    output logic              wbSyscall,
    output logic              wbBrk
);

    trapPkg::busStateT state;
    logic              accept;
    logic              needBus;
    logic              startBus;
    logic              commit;
    logic [3:0]        laneSel;
    dataPkg::wordT     laneData;

    assign accept = memValid && !stall;

    // A faulting instruction never reaches the bus.
    assign needBus = (memRead || memWrite) && (excCode == trapPkg::excNone);
    assign startBus = (state == trapPkg::idle) && accept && needBus;
    assign commit = (state == trapPkg::waitAck) ? wbAck : (accept && !needBus);

    assign stall = (state == trapPkg::waitAck);
    assign wbCyc = (state == trapPkg::waitAck);
    assign wbStb = (state == trapPkg::waitAck);

    // Stores place the data on every lane and enable only the addressed bytes.
    always_comb
    begin
        laneSel = 4'b1111;
        laneData = storeData;
        if (memWrite)
        begin
            case (loadType[1:0])
                dataPkg::sizeByte:
                begin
                    laneSel = 4'b0001 << aluOut[1:0];
                    laneData = {4{storeData[7:0]}};
                end
                dataPkg::sizeHalf:
                begin
                    laneSel = aluOut[1] ? 4'b1100 : 4'b0011;
                    laneData = {2{storeData[15:0]}};
                end
                default:
                begin
                    laneSel = 4'b1111;
                    laneData = storeData;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= trapPkg::idle;
        else if (startBus)
            state <= trapPkg::waitAck;
        else if (state == trapPkg::waitAck && wbAck)
            state <= trapPkg::idle;
    end

    always_ff @(posedge clk)
    begin
        if (startBus)
        begin
            wbWe <= memWrite;
            wbAdr <= {aluOut[31:2], 2'b00}; // Word aligned, lanes pick the bytes.
            wbSel <= laneSel;
            wbDatW <= laneData;
        end
    end

    // MEM/WB register. It holds one instruction for a single cycle.
    always_ff @(posedge clk)
    begin
        if (rst)
            wbValid <= 1'b0;
        else
            wbValid <= commit;
    end

    always_ff @(posedge clk)
    begin
        if (commit)
        begin
            wbAluOut <= aluOut;
            wbMemData <= (state == trapPkg::waitAck) ? wbDatR : '0; // Raw word.
            wbLoadType <= loadType;
            wbRegWrite <= regWrite;
            wbMemToReg <= memToReg;
            wbRfAddr <= rfAddr;
            wbHiLoWrite <= hiLoWrite;
            wbHiLoData <= hiLoData;
            wbPc <= pc;
            wbEpc <= epc;
            wbExcCode <= excCode;
            wbExcAddrSel <= excAddrSel;
            wbExcDataSel <= excDataSel;
            wbExcAddr <= excAddr;
            wbExcData <= excData;
            wbSyscall <= syscall;
            wbBrk <= brk;
        end
    end

endmodule

/* rtl/memWbTop.sv */
module memWbTop
(
    input  logic              clk,
    input  logic              rst,
    input  logic              memValid,
    input  dataPkg::wordT     aluOut,
    input  dataPkg::wordT     storeData,
    input  dataPkg::loadTypeT loadType,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              regWrite,
    input  logic              memToReg,
    input  dataPkg::regAddrT  rfAddr,
    input  logic              hiLoWrite,
    input  dataPkg::hiLoT     hiLoData,
    input  dataPkg::wordT     pc,
    input  dataPkg::wordT     epc,
    input  trapPkg::excCodeT  excCode,
    input  logic              excAddrSel,
    input  logic              excDataSel,
    input  dataPkg::regAddrT  excAddr,
    input  dataPkg::wordT     excData,
    input  logic              syscall,
    input  logic              brk,
    output logic              stall,
    output logic              wbCyc,
    output logic              wbStb,
    output logic              wbWe,
    output dataPkg::wordT     wbAdr,
    output dataPkg::wordT     wbDatW,
    output logic [3:0]        wbSel,
    input  dataPkg::wordT     wbDatR,
    input  logic              wbAck,
    input  dataPkg::regAddrT  rdAddr,
    output dataPkg::wordT     rdData,
    output dataPkg::wordT     hi,
    output dataPkg::wordT     lo,
    output trapPkg::excCodeT  excOut,
    output dataPkg::wordT     pcOut,
    output logic              syscallOut,
    output logic              brkOut
);

    // MEM/WB register contents.
    logic              wbValid;
    dataPkg::wordT     wbAluOut;
    dataPkg::wordT     wbMemData;
    dataPkg::loadTypeT wbLoadType;
    logic              wbRegWrite;
    logic              wbMemToReg;
    dataPkg::regAddrT  wbRfAddr;
    logic              wbHiLoWrite;
    dataPkg::hiLoT     wbHiLoData;
    dataPkg::wordT     wbPc;
    dataPkg::wordT     wbEpc;
    trapPkg::excCodeT  wbExcCode;
    logic              wbExcAddrSel;
    logic              wbExcDataSel;
    dataPkg::regAddrT  wbExcAddr;
    dataPkg::wordT     wbExcData;
    logic              wbSyscall;
    logic              wbBrk;

    // Register file write side.
    logic              rfWe;
    dataPkg::regAddrT  rfWAddr;
    dataPkg::wordT     rfWData;
    logic              hiLoWe;
    dataPkg::hiLoT     hiLoWData;

    memAccess memAccess_inst
    (
        .*
    );

    writeBack writeBack_inst
    (
        .*
    );

    regFile regFile_inst
    (
        .we(rfWe),
        .wAddr(rfWAddr),
        .wData(rfWData),
        .*
    );

endmodule

/* rtl/regFile.sv */
`include "cpu_cfg.svh"

module regFile
(
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  dataPkg::regAddrT wAddr,
    input  dataPkg::wordT    wData,
    input  logic             hiLoWe,
    input  dataPkg::hiLoT    hiLoWData,
    input  dataPkg::regAddrT rdAddr,
    output dataPkg::wordT    rdData,
    output dataPkg::wordT    hi,
    output dataPkg::wordT    lo
);

    dataPkg::wordT gpr [`CFG_GPR_COUNT];
    dataPkg::wordT excReg [`CFG_EXC_REG_COUNT];
    dataPkg::hiLoT hiLo;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CFG_GPR_COUNT; i++)
                gpr[i] <= '0;
            for (int i = 0; i < `CFG_EXC_REG_COUNT; i++)
                excReg[i] <= '0;
            hiLo <= '0;
        end
        else
        begin
            if (we)
            begin
                if (wAddr[6])
                    excReg[wAddr[2:0]] <= wData;
                else if (wAddr[4:0] != 5'd0)
                    gpr[wAddr[4:0]] <= wData; // Register 0 stays zero.
            end
            if (hiLoWe)
                hiLo <= hiLoWData;
        end
    end

    assign rdData = rdAddr[6] ? excReg[rdAddr[2:0]] : gpr[rdAddr[4:0]];
    assign hi = hiLo[63:32];
    assign lo = hiLo[31:0];

endmodule

/* rtl/trapPkg.sv */
package trapPkg;

    typedef logic [3:0] excCodeT;

    // Code of an instruction that raised nothing.
    localparam excCodeT excNone = 4'd0;

    // Data bus master states in memAccess.
    typedef enum logic
    {
        idle,
        waitAck
    } busStateT;

endpackage

/* rtl/writeBack.sv */
`include "cpu_cfg.svh"

module writeBack
(
    input  logic              wbValid,
    input  dataPkg::wordT     wbAluOut,
    input  dataPkg::wordT     wbMemData,
    input  dataPkg::loadTypeT wbLoadType,
    input  logic              wbRegWrite,
    input  logic              wbMemToReg,
    input  dataPkg::regAddrT  wbRfAddr,
    input  logic              wbHiLoWrite,
    input  dataPkg::hiLoT     wbHiLoData,
    input  dataPkg::wordT     wbPc,
    input  dataPkg::wordT     wbEpc,
    input  trapPkg::excCodeT  wbExcCode,
    input  logic              wbExcAddrSel,
    input  logic              wbExcDataSel,
    input  dataPkg::regAddrT  wbExcAddr,
    input  dataPkg::wordT     wbExcData,
    input  logic              wbSyscall,
    input  logic              wbBrk,
    output logic              rfWe,
    output dataPkg::regAddrT  rfWAddr,
    output dataPkg::wordT     rfWData,
    output logic              hiLoWe,
    output dataPkg::hiLoT     hiLoWData,
    output trapPkg::excCodeT  excOut,
    output dataPkg::wordT     pcOut,
    output logic              syscallOut,
    output logic              brkOut
);

    logic [7:0]    laneByte;
    logic [15:0]   laneHalf;
    logic          signExt;
    dataPkg::wordT loadData;
    dataPkg::wordT result;
    logic          commitOk;

    assign signExt = wbLoadType[2];
    assign laneByte = wbMemData[{wbAluOut[1:0], 3'b000} +: 8];
    assign laneHalf = wbAluOut[1] ? wbMemData[31:16] : wbMemData[15:0];

    always_comb
    begin
        case (wbLoadType[1:0])
            dataPkg::sizeByte:
                loadData = {{24{signExt & laneByte[7]}}, laneByte};
            dataPkg::sizeHalf:
                loadData = {{16{signExt & laneHalf[15]}}, laneHalf};
            default:
                loadData = wbMemData;
        endcase
    end

    assign result = wbMemToReg ? wbAluOut : loadData; // Set keeps the ALU value.
    assign rfWData = wbExcDataSel ? wbExcData : result;
    assign rfWAddr = wbExcAddrSel ? wbExcAddr : wbRfAddr;

    // The commit code only writes back when the faulting EPC was word aligned.
    assign commitOk = wbValid &&
                      ((wbExcCode == trapPkg::excNone) ||
                       (wbExcCode == trapPkg::excCodeT'(`CFG_COMMIT_EXC) &&
                        wbEpc[1:0] == 2'b00));

    assign rfWe = commitOk && wbRegWrite;
    assign hiLoWe = commitOk && wbHiLoWrite;
    assign hiLoWData = wbHiLoData;

    assign excOut = wbValid ? wbExcCode : trapPkg::excNone;
    assign pcOut = wbPc;
    assign syscallOut = wbValid && wbSyscall;
    assign brkOut = wbValid && wbBrk;

endmodule

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -f list.f --top-module memWbTop_tb -Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

# The run passes only if the testbench printed its pass line.
grep -q "All checks passed" sim.log

/* test/memWbTop_asserts.sv */
module memWbTop_asserts
(
    input logic          clk,
    input logic          rst,
    input logic          stall,
    input logic          wbCyc,
    input logic          wbStb,
    input logic          wbWe,
    input dataPkg::wordT wbAdr,
    input dataPkg::wordT wbDatW,
    input logic [3:0]    wbSel,
    input logic          wbAck
);

    // Classic cycle. The request holds still until the slave acknowledges.
    heldUntilAck: assert property (@(posedge clk) disable iff (rst)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbWe) && $stable(wbAdr) &&
                               $stable(wbSel) && $stable(wbDatW)))
        else $error("Wishbone request changed before ack");

    dropAfterAck: assert property (@(posedge clk) disable iff (rst) (wbStb && wbAck) |=> !wbStb)
        else $error("Wishbone strobe stayed high after ack");

    quietAfterReset: assert property (@(posedge clk) rst |=> (!stall && !wbCyc))
        else $error("Stall or cyc high right after reset");

endmodule

bind memAccess memWbTop_asserts memWbTop_asserts_inst (.*);

/* test/memWbTop_tb.sv */
`include "cpu_cfg.svh"

module memWbTop_tb;

    localparam int kindAlu = 0;
    localparam int kindLoad = 1;
    localparam int kindStore = 2;
    localparam int kindExcReg = 3;
    localparam int kindHiLo = 4;
    localparam int timeoutCycles = 50;

    typedef struct {
        int                kind;
        dataPkg::wordT     addr;
        dataPkg::wordT     data;
        dataPkg::loadTypeT lt;
        dataPkg::regAddrT  dest;
        trapPkg::excCodeT  exc;
        dataPkg::wordT     epc;
        dataPkg::wordT     expected;
    } rowT;

    logic              clk, rst, memValid, memRead, memWrite, regWrite, memToReg;
    logic              hiLoWrite, excAddrSel, excDataSel, syscall, brk;
    dataPkg::wordT     aluOut, storeData, pc, epc, excData;
    dataPkg::loadTypeT loadType;
    dataPkg::regAddrT  rfAddr, excAddr, rdAddr;
    dataPkg::hiLoT     hiLoData;
    trapPkg::excCodeT  excCode, excOut;
    logic              stall, wbCyc, wbStb, wbWe, wbAck, syscallOut, brkOut;
    logic [3:0]        wbSel;
    dataPkg::wordT     wbAdr, wbDatW, wbDatR, rdData, hi, lo, pcOut;

    rowT           rows [48];
    int            rowCount;
    dataPkg::wordT shadowMem [64];
    dataPkg::wordT expHi;
    dataPkg::wordT expLo;
    int            errorCount;
    int            timeoutCount;

    memWbTop memWbTop_inst (.*);

    wbMemModel mem_inst (.*);

    always #50 clk = ~clk;

    function automatic logic commits(trapPkg::excCodeT exc, dataPkg::wordT epcVal);
        return (exc == 4'd0) ||
               (exc == trapPkg::excCodeT'(`CFG_COMMIT_EXC) && epcVal[1:0] == 2'b00);
    endfunction

    function automatic dataPkg::wordT extract(dataPkg::wordT word, logic [1:0] off,
                                              dataPkg::loadTypeT lt);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (lt[1:0])
            2'd0: return {{24{lt[2] & b[7]}}, b};
            2'd1: return {{16{lt[2] & h[15]}}, h};
            default: return word;
        endcase
    endfunction

    // Keeps pc apart from epc, with the opposite alignment.
    function automatic dataPkg::wordT pcFor(rowT r);
        return r.epc ^ 32'h0000_1002;
    endfunction

    // Reference model. Works out what a row leaves behind and queues it.
    task automatic addRow(int kind, dataPkg::wordT addr, dataPkg::wordT data,
                          dataPkg::loadTypeT lt, dataPkg::regAddrT dest,
                          trapPkg::excCodeT exc, dataPkg::wordT epcVal);
        rowT           r;
        logic          ok;
        int            idx;
        dataPkg::wordT word;
        ok = commits(exc, epcVal);
        idx = int'(addr[7:2]);
        word = (exc == 4'd0) ? shadowMem[idx] : 32'h0; // Faulting loads skip the bus.
        r = '{kind, addr, data, lt, dest, exc, epcVal, 32'h0};
        case (kind)
            kindAlu, kindExcReg:
                if (ok)
                    r.expected = data;
            kindLoad:
                if (ok)
                    r.expected = extract(word, addr[1:0], lt);
            kindStore:
                if (exc == 4'd0)
                    case (lt[1:0])
                        2'd0: shadowMem[idx][8*addr[1:0] +: 8] = data[7:0];
                        2'd1: shadowMem[idx][16*addr[1] +: 16] = data[15:0];
                        default: shadowMem[idx] = data;
                    endcase
            default:
                if (ok)
                begin
                    expHi = data;
                    expLo = ~data;
                end
        endcase
        if (!dest[6] && dest[4:0] == 5'd0)
            r.expected = 32'h0;
        rows[rowCount] = r;
        rowCount++;
    endtask

    task automatic clearInputs();
        memValid = 1'b0;
        {memRead, memWrite, regWrite, memToReg, hiLoWrite} = 5'b0;
        {excAddrSel, excDataSel, syscall, brk} = 4'b0;
        {aluOut, storeData, pc, epc, excData} = '0;
        {loadType, rfAddr, excAddr, excCode, hiLoData} = '0;
    endtask

    task automatic driveRow(rowT r);
        memValid = 1'b1;
        if (r.kind == kindLoad || r.kind == kindStore)
            aluOut = r.addr;
        else if (r.kind == kindExcReg)
            aluOut = ~r.data; // The exception data must win over this value.
        else
            aluOut = r.data;
        storeData = r.data;
        loadType = r.lt;
        memRead = (r.kind == kindLoad);
        memWrite = (r.kind == kindStore);
        regWrite = (r.kind == kindAlu || r.kind == kindLoad || r.kind == kindExcReg);
        memToReg = (r.kind != kindLoad); // High keeps the ALU result.
        rfAddr = (r.kind == kindExcReg) ? 7'd0 : r.dest; // The exception address must override.
        hiLoWrite = (r.kind == kindHiLo);
        hiLoData = {r.data, ~r.data};
        pc = pcFor(r);
        epc = r.epc;
        excCode = r.exc;
        excAddrSel = (r.kind == kindExcReg);
        excDataSel = (r.kind == kindExcReg);
        excAddr = r.dest;
        excData = r.data;
        // MIPS codes 8 and 9 are syscall and break.
        syscall = (r.exc == 4'd8);
        brk = (r.exc == 4'd9);
    endtask

    task automatic waitStallLow();
        int cycles;
        cycles = 0;
        while (stall && cycles < timeoutCycles)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (stall)
        begin
            $display("Timeout: stall stayed high for %0d cycles at time %0t", cycles, $time);
            timeoutCount++;
        end
    endtask

    // The instruction sits in the MEM/WB register for this one cycle.
    task automatic checkTrapOutputs(rowT r, int idx);
        assert (excOut == r.exc && pcOut == pcFor(r) &&
                syscallOut == (r.exc == 4'd8) && brkOut == (r.exc == 4'd9))
        else
        begin
            $display("FAILED at time %0t: row %0d exc/pc/sys/brk %h/%h/%b/%b, expected %h/%h",
                     $time, idx, excOut, pcOut, syscallOut, brkOut, r.exc, pcFor(r));
            errorCount++;
        end
    endtask

    initial
    begin
        errorCount = 0;
        timeoutCount = 0;
        rowCount = 0;
        expHi = 32'h0;
        expLo = 32'h0;
        void'($urandom(32'h608d));
        clk = 1'b0;
        rst = 1'b1;
        rdAddr = '0;
        clearInputs();
        @(posedge clk);
        #1;
        for (int i = 0; i < 64; i++)
            shadowMem[i] = mem_inst.mem[i]; // The slave fills its memory in reset.

        addRow(kindAlu, 32'h0, 32'h1234_5678, 3'b000, 7'd1, 4'd0, 32'h0);
        addRow(kindAlu, 32'h0, 32'hdead_beef, 3'b000, 7'd0, 4'd0, 32'h0);
        for (int i = 0; i < 4; i++)
            addRow(kindLoad, 32'h10 + i, 32'h0, 3'b000, 7'(2 + i), 4'd0, 32'h0);
        for (int i = 0; i < 4; i++)
            addRow(kindLoad, 32'h10 + i, 32'h0, 3'b100, 7'(6 + i), 4'd0, 32'h0);
        addRow(kindLoad, 32'h20, 32'h0, 3'b001, 7'd10, 4'd0, 32'h0);
        addRow(kindLoad, 32'h22, 32'h0, 3'b001, 7'd11, 4'd0, 32'h0);
        addRow(kindLoad, 32'h20, 32'h0, 3'b101, 7'd12, 4'd0, 32'h0);
        addRow(kindLoad, 32'h22, 32'h0, 3'b101, 7'd13, 4'd0, 32'h0);
        addRow(kindLoad, 32'h24, 32'h0, 3'b010, 7'd14, 4'd0, 32'h0);
        addRow(kindLoad, 32'h24, 32'h0, 3'b110, 7'd15, 4'd0, 32'h0);
        addRow(kindStore, 32'h29, 32'h0000_005a, 3'b000, 7'd0, 4'd0, 32'h0);
        addRow(kindStore, 32'h2a, 32'h0000_1234, 3'b001, 7'd0, 4'd0, 32'h0);
        addRow(kindLoad, 32'h28, 32'h0, 3'b010, 7'd16, 4'd0, 32'h0);
        addRow(kindLoad, 32'h2a, 32'h0, 3'b101, 7'd17, 4'd0, 32'h0);
        addRow(kindStore, 32'h30, 32'h0bad_f00d, 3'b010, 7'd0, 4'd3, 32'h0);
        addRow(kindLoad, 32'h30, 32'h0, 3'b010, 7'd18, 4'd0, 32'h0);
        addRow(kindAlu, 32'h0, 32'h5555_0001, 3'b000, 7'd19, 4'd3, 32'h0);
        addRow(kindAlu, 32'h0, 32'h5555_0002, 3'b000, 7'd20, 4'd6, 32'h100);
        addRow(kindAlu, 32'h0, 32'h5555_0003, 3'b000, 7'd21, 4'd6, 32'h102);
        addRow(kindExcReg, 32'h0, 32'hcafe_0001, 3'b000, 7'h43, 4'd0, 32'h0);
        addRow(kindExcReg, 32'h0, 32'hcafe_0002, 3'b000, 7'h45, 4'd2, 32'h0);
        addRow(kindHiLo, 32'h0, 32'h1111_2222, 3'b000, 7'd0, 4'd0, 32'h0);
        addRow(kindHiLo, 32'h0, 32'h7777_8888, 3'b000, 7'd0, 4'd5, 32'h0);
        addRow(kindAlu, 32'h0, 32'h5555_0004, 3'b000, 7'd22, 4'd8, 32'h104);
        addRow(kindAlu, 32'h0, 32'h5555_0005, 3'b000, 7'd23, 4'd9, 32'h108);

        @(posedge clk);
        @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < rowCount; i++)
        begin
            driveRow(rows[i]);
            @(posedge clk);
            #1;
            waitStallLow();
            checkTrapOutputs(rows[i], i);
        end
        clearInputs();
        repeat (2) @(posedge clk);
        #1;

        assert (excOut == 4'd0 && !syscallOut && !brkOut)
        else
        begin
            $display("FAILED at time %0t: exc/sys/brk read %h/%b/%b with nothing committed",
                     $time, excOut, syscallOut, brkOut);
            errorCount++;
        end

        for (int i = 0; i < rowCount; i++)
        begin
            rdAddr = rows[i].dest;
            #1;
            assert (rdData == rows[i].expected)
            else
            begin
                $display("FAILED at time %0t: row %0d register %h reads %h, expected %h",
                         $time, i, rows[i].dest, rdData, rows[i].expected);
                errorCount++;
            end
        end
        assert (hi == expHi && lo == expLo)
        else
        begin
            $display("FAILED at time %0t: hi/lo read %h/%h, expected %h/%h",
                     $time, hi, lo, expHi, expLo);
            errorCount++;
        end

        $display("Errors: %0d wrong values, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* test/wbMemModel.sv */
module wbMemModel
(
    input  logic          clk,
    input  logic          rst,
    input  logic          wbCyc,
    input  logic          wbStb,
    input  logic          wbWe,
    input  dataPkg::wordT wbAdr,
    input  dataPkg::wordT wbDatW,
    input  logic [3:0]    wbSel,
    output dataPkg::wordT wbDatR,
    output logic          wbAck
);

    dataPkg::wordT mem [64];
    int            waitLeft;
    logic [5:0]    index;

    assign index = wbAdr[7:2];

    always @(posedge clk)
    begin
        if (rst)
        begin
            wbAck <= 1'b0;
            waitLeft <= 0;
            // Every word gets a value that depends on its whole index.
            for (int i = 0; i < 64; i++)
                mem[i] <= 32'h8a3f_c6f1 ^ (i * 32'h0101_0101);
        end
        else if (wbCyc && wbStb && !wbAck)
        begin
            if (waitLeft == 0)
            begin
                wbAck <= 1'b1;
                wbDatR <= mem[index];
                if (wbWe)
                    for (int b = 0; b < 4; b++)
                        if (wbSel[b])
                            mem[index][8*b +: 8] <= wbDatW[8*b +: 8];
            end
            else
                waitLeft <= waitLeft - 1;
        end
        else
        begin
            wbAck <= 1'b0;
            waitLeft <= int'($urandom % 4); // Wait states for the next cycle.
        end
    end

endmodule
